// File: rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// First fetch address after reset.
`define RV_RESET_ADDR 32'h0000_0000

// Low instruction address bits that the fetcher drives.
`define RV_IADDR_BITS 16

// Prefetch buffer holds 2**N words.
`define RV_IBUF_DEPTH_BITS 2

`endif

// File: rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

    typedef logic [31:0] word_t;                        // Bus word.
    typedef logic [`RV_IADDR_BITS-3:0] iaddr_t;         // Word index.
    typedef logic [3:0] bsel_t;

    typedef enum logic [1:0]
    {
        LS_BYTE = 2'd0,
        LS_HALF = 2'd1,
        LS_WORD = 2'd2
    } ls_size_e;

    typedef enum logic [1:0]
    {
        LSU_IDLE = 2'd0,
        LSU_BUS  = 2'd1,
        LSU_DONE = 2'd2
    } lsu_state_e;

    typedef enum logic [1:0]
    {
        OWN_NONE  = 2'd0,
        OWN_FETCH = 2'd1,
        OWN_DATA  = 2'd2
    } arb_owner_e;

endpackage

// File: rv_bus_if.sv
`timescale 1ns/1ps

interface fetch_bus_if;
    logic           req;
    rv_pkg::iaddr_t addr;
    logic           ack;
    rv_pkg::word_t  rdata;

    modport fetch
    (
        output req,
        output addr,
        input  ack,
        input  rdata
    );

    modport arbiter
    (
        input  req,
        input  addr,
        output ack,
        output rdata
    );
endinterface

interface data_bus_if;
    logic           req;
    logic           we;
    rv_pkg::word_t  addr;
    rv_pkg::word_t  wdata;
    rv_pkg::bsel_t  sel;
    logic           ack;                                // Registered ack.
    rv_pkg::word_t  rdata;

    modport lsu
    (
        output req,
        output we,
        output addr,
        output wdata,
        output sel,
        input  ack,
        input  rdata
    );

    modport arbiter
    (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        input  sel,
        output ack,
        output rdata
    );
endinterface

// File: rv_fetch.sv
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_fetch
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_redirect,
    input  rv_pkg::word_t   i_redirect_pc,
    input  logic            i_instr_pop,
    output logic            o_instr_valid,
    output rv_pkg::word_t   o_instr,
    output rv_pkg::word_t   o_instr_pc,
    fetch_bus_if.fetch      bus
);

    localparam int DB = `RV_IBUF_DEPTH_BITS;
    localparam int DEPTH = 1 << DB;
    localparam rv_pkg::word_t RESET_ADDR = `RV_RESET_ADDR;

    rv_pkg::word_t  buf_data [DEPTH];
    rv_pkg::iaddr_t buf_pc [DEPTH];

    logic [DB:0]    wr_ptr;
    logic [DB:0]    rd_ptr;
    logic [DB:0]    count;
    logic           full;
    logic           fill;
    logic           pop;
    logic           discard;                            // In-flight word is stale.
    rv_pkg::iaddr_t req_idx;
    rv_pkg::iaddr_t next_idx;
    rv_pkg::iaddr_t redirect_idx;

    assign count = wr_ptr - rd_ptr;
    assign full = count[DB];                            // Count never exceeds depth.
    assign redirect_idx = i_redirect_pc[`RV_IADDR_BITS-1:2];

    // A request is outstanding whenever req is up, so entries plus one fit.
    assign bus.req = !full;
    assign bus.addr = req_idx;

    assign fill = bus.ack && !discard && !i_redirect;
    assign pop = i_instr_pop && o_instr_valid && !i_redirect;

    assign o_instr_valid = (count != '0);
    assign o_instr = buf_data[rd_ptr[DB-1:0]];
    assign o_instr_pc = {RESET_ADDR[31:`RV_IADDR_BITS], buf_pc[rd_ptr[DB-1:0]], 2'b00};

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            discard  <= 1'b0;
            req_idx  <= RESET_ADDR[`RV_IADDR_BITS-1:2];
            next_idx <= RESET_ADDR[`RV_IADDR_BITS-1:2] + 1'b1;
        end
        else
        begin
            if (i_redirect)
            begin
                wr_ptr <= '0;                           // Flush.
                rd_ptr <= '0;
            end
            else
            begin
                if (fill)
                    wr_ptr <= wr_ptr + 1'b1;
                if (pop)
                    rd_ptr <= rd_ptr + 1'b1;
            end

            if (i_redirect && bus.req && !bus.ack)
            begin
                // Request must finish at its old address.
                discard  <= 1'b1;
                next_idx <= redirect_idx;
            end
            else if (i_redirect)
            begin
                discard  <= 1'b0;
                req_idx  <= redirect_idx;
                next_idx <= redirect_idx + 1'b1;
            end
            else if (bus.ack)
            begin
                discard  <= 1'b0;
                req_idx  <= next_idx;
                next_idx <= next_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (fill)
        begin
            buf_data[wr_ptr[DB-1:0]] <= bus.rdata;
            buf_pc[wr_ptr[DB-1:0]]   <= req_idx;
        end
    end

endmodule

// File: rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_ls_start,
    input  logic                i_ls_write,
    input  rv_pkg::word_t       i_ls_addr,
    input  rv_pkg::word_t       i_ls_wdata,
    input  rv_pkg::ls_size_e    i_ls_size,
    input  logic                i_ls_unsigned,
    output logic                o_ls_busy,
    output logic                o_ls_done,
    output logic                o_ls_misaligned,
    output rv_pkg::word_t       o_ls_rdata,
    data_bus_if.lsu             bus
);

    rv_pkg::lsu_state_e state_q;
    logic               mis_q;
    logic               start_ok;
    logic               misaligned;

    logic               write_q;
    logic               unsigned_q;
    rv_pkg::ls_size_e   size_q;
    rv_pkg::word_t      addr_q;
    rv_pkg::word_t      wdata_q;
    rv_pkg::word_t      rdata_q;

    rv_pkg::word_t      shifted;
    rv_pkg::word_t      load_ext;
    rv_pkg::word_t      lane_wdata;
    rv_pkg::bsel_t      sel;

    assign start_ok = i_ls_start && (state_q != rv_pkg::LSU_BUS);
    assign misaligned = ((i_ls_size == rv_pkg::LS_HALF) && i_ls_addr[0]) ||
                        ((i_ls_size == rv_pkg::LS_WORD) && (i_ls_addr[1:0] != 2'b00));

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state_q <= rv_pkg::LSU_IDLE;
            mis_q   <= 1'b0;
        end
        else if (state_q == rv_pkg::LSU_BUS)
        begin
            if (bus.ack)
                state_q <= rv_pkg::LSU_DONE;
        end
        else if (i_ls_start)
        begin
            state_q <= misaligned ? rv_pkg::LSU_DONE : rv_pkg::LSU_BUS;   // No bus on fault.
            mis_q   <= misaligned;
        end
        else
        begin
            state_q <= rv_pkg::LSU_IDLE;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (start_ok)
        begin
            write_q    <= i_ls_write;
            unsigned_q <= i_ls_unsigned;
            size_q     <= i_ls_size;
            addr_q     <= i_ls_addr;
            wdata_q    <= i_ls_wdata;
        end
        if ((state_q == rv_pkg::LSU_BUS) && bus.ack)
            rdata_q <= load_ext;
    end

    always_comb
    begin
        shifted = bus.rdata >> {addr_q[1:0], 3'b000};   // Lane down to bit 0.
        case (size_q)
            rv_pkg::LS_BYTE:
            begin
                load_ext   = {{24{shifted[7] & !unsigned_q}}, shifted[7:0]};
                lane_wdata = {4{wdata_q[7:0]}};
                sel        = 4'b0001 << addr_q[1:0];
            end
            rv_pkg::LS_HALF:
            begin
                load_ext   = {{16{shifted[15] & !unsigned_q}}, shifted[15:0]};
                lane_wdata = {2{wdata_q[15:0]}};
                sel        = 4'b0011 << addr_q[1:0];
            end
            default:
            begin
                load_ext   = shifted;
                lane_wdata = wdata_q;
                sel        = 4'b1111;
            end
        endcase
    end

    assign bus.req   = (state_q == rv_pkg::LSU_BUS);
    assign bus.we    = write_q;
    assign bus.addr  = {addr_q[31:2], 2'b00};
    assign bus.wdata = lane_wdata;
    assign bus.sel   = sel;

    assign o_ls_busy       = (state_q == rv_pkg::LSU_BUS);
    assign o_ls_done       = (state_q == rv_pkg::LSU_DONE);
    assign o_ls_misaligned = o_ls_done && mis_q;
    assign o_ls_rdata      = rdata_q;

endmodule

// File: rv_wb_arbiter.sv
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_wb_arbiter
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    fetch_bus_if.arbiter    fetch,
    data_bus_if.arbiter     data,
    output rv_pkg::word_t   o_wb_adr,
    output rv_pkg::word_t   o_wb_dat,
    input  rv_pkg::word_t   i_wb_dat,
    output logic            o_wb_we,
    output rv_pkg::bsel_t   o_wb_sel,
    output logic            o_wb_stb,
    output logic            o_wb_cyc,
    input  logic            i_wb_ack
);

    localparam rv_pkg::word_t RESET_ADDR = `RV_RESET_ADDR;

    rv_pkg::arb_owner_e owner_q;
    logic               data_own;
    logic               data_ack_q;
    rv_pkg::word_t      data_rdata_q;

    assign data_own = (owner_q == rv_pkg::OWN_DATA);

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            owner_q    <= rv_pkg::OWN_NONE;
            data_ack_q <= 1'b0;
        end
        else
        begin
            data_ack_q <= i_wb_ack && data_own;
            if (owner_q == rv_pkg::OWN_NONE)
            begin
                // LSU still holds req while its ack is pending.
                if (data.req && !data_ack_q)
                    owner_q <= rv_pkg::OWN_DATA;
                else if (fetch.req)
                    owner_q <= rv_pkg::OWN_FETCH;
            end
            else if (i_wb_ack)
            begin
                owner_q <= rv_pkg::OWN_NONE;            // Release in ack cycle.
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_wb_ack && data_own)
            data_rdata_q <= i_wb_dat;
    end

    assign fetch.ack   = i_wb_ack && (owner_q == rv_pkg::OWN_FETCH);
    assign fetch.rdata = i_wb_dat;
    assign data.ack    = data_ack_q;
    assign data.rdata  = data_rdata_q;

    assign o_wb_adr = data_own ? data.addr
                               : {RESET_ADDR[31:`RV_IADDR_BITS], fetch.addr, 2'b00};
    assign o_wb_dat = data.wdata;
    assign o_wb_we  = data_own && data.we;
    assign o_wb_sel = data_own ? data.sel : 4'b1111;
    assign o_wb_cyc = (owner_q != rv_pkg::OWN_NONE);
    assign o_wb_stb = o_wb_cyc;

endmodule

// File: rv_top_wb.sv
`timescale 1ns/1ps

module rv_top_wb
(
    input  logic                i_clk,
    input  logic                i_rst_n,

    input  logic                i_redirect,
    input  rv_pkg::word_t       i_redirect_pc,
    input  logic                i_instr_pop,
    output logic                o_instr_valid,
    output rv_pkg::word_t       o_instr,
    output rv_pkg::word_t       o_instr_pc,

    input  logic                i_ls_start,
    input  logic                i_ls_write,
    input  rv_pkg::word_t       i_ls_addr,
    input  rv_pkg::word_t       i_ls_wdata,
    input  rv_pkg::ls_size_e    i_ls_size,
    input  logic                i_ls_unsigned,
    output logic                o_ls_busy,
    output logic                o_ls_done,
    output logic                o_ls_misaligned,
    output rv_pkg::word_t       o_ls_rdata,

    output rv_pkg::word_t       o_wb_adr,
    output rv_pkg::word_t       o_wb_dat,
    input  rv_pkg::word_t       i_wb_dat,
    output logic                o_wb_we,
    output rv_pkg::bsel_t       o_wb_sel,
    output logic                o_wb_stb,
    output logic                o_wb_cyc,
    input  logic                i_wb_ack
);

    fetch_bus_if    fetch_bus ();
    data_bus_if     data_bus ();

    rv_fetch u_fetch
    (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_redirect         (i_redirect),
        .i_redirect_pc      (i_redirect_pc),
        .i_instr_pop        (i_instr_pop),
        .o_instr_valid      (o_instr_valid),
        .o_instr            (o_instr),
        .o_instr_pc         (o_instr_pc),
        .bus                (fetch_bus.fetch)
    );

    rv_lsu u_lsu
    (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_ls_start         (i_ls_start),
        .i_ls_write         (i_ls_write),
        .i_ls_addr          (i_ls_addr),
        .i_ls_wdata         (i_ls_wdata),
        .i_ls_size          (i_ls_size),
        .i_ls_unsigned      (i_ls_unsigned),
        .o_ls_busy          (o_ls_busy),
        .o_ls_done          (o_ls_done),
        .o_ls_misaligned    (o_ls_misaligned),
        .o_ls_rdata         (o_ls_rdata),
        .bus                (data_bus.lsu)
    );

    rv_wb_arbiter u_arbiter
    (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .fetch              (fetch_bus.arbiter),
        .data               (data_bus.arbiter),
        .o_wb_adr           (o_wb_adr),
        .o_wb_dat           (o_wb_dat),
        .i_wb_dat           (i_wb_dat),
        .o_wb_we            (o_wb_we),
        .o_wb_sel           (o_wb_sel),
        .o_wb_stb           (o_wb_stb),
        .o_wb_cyc           (o_wb_cyc),
        .i_wb_ack           (i_wb_ack)
    );

endmodule

// File: tb_wb_mem.sv
`timescale 1ns/1ps

module tb_wb_mem
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic [31:0] i_wb_adr,
    input  logic [31:0] i_wb_dat,
    output logic [31:0] o_wb_dat,
    input  logic        i_wb_we,
    input  logic [3:0]  i_wb_sel,
    input  logic        i_wb_stb,
    input  logic        i_wb_cyc,
    output logic        o_wb_ack
);

    logic [31:0] mem [4096];
    logic [15:0] lfsr_q;
    logic [15:0] lfsr_a;
    logic [15:0] lfsr_b;
    logic [1:0]  wait_q;
    logic [11:0] idx;
    logic        take;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1.
    endfunction

    assign lfsr_a = lfsr_step(lfsr_q);
    assign lfsr_b = lfsr_step(lfsr_a);
    assign idx = i_wb_adr[13:2];
    assign take = i_wb_cyc && i_wb_stb && !o_wb_ack && (wait_q == 2'd0);

    initial
    begin
        for (int i = 0; i < 4096; i++)
            mem[i] <= {4'hc, 12'(i), 4'h5, ~12'(i)};
    end

    always @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_wb_ack <= 1'b0;
            o_wb_dat <= '0;
            lfsr_q   <= 16'd52582;
            wait_q   <= 2'd0;
        end
        else
        begin
            o_wb_ack <= take;
            if (take)
            begin
                o_wb_dat <= mem[idx];
                lfsr_q   <= lfsr_b;
                wait_q   <= {lfsr_a[0], lfsr_b[0]};        // Delay of the next access.
            end
            else if (i_wb_cyc && i_wb_stb && !o_wb_ack)
                wait_q <= wait_q - 2'd1;
        end
    end

    always @(posedge i_clk)
    begin
        if (take && i_wb_we)
        begin
            for (int b = 0; b < 4; b++)
                if (i_wb_sel[b])
                    mem[idx][8*b +: 8] <= i_wb_dat[8*b +: 8];
        end
    end

endmodule

// File: tb_rv_top_wb.sv
`timescale 1ns/1ps

`include "rv_params.svh"

module tb_rv_top_wb;

    localparam int TIMEOUT = 100;
    localparam logic [31:0] RESET_ADDR = `RV_RESET_ADDR;

    logic               i_clk = 1'b0;
    logic               i_rst_n;
    logic               i_redirect;
    logic               i_instr_pop;
    logic               o_instr_valid;
    rv_pkg::word_t      i_redirect_pc;
    rv_pkg::word_t      o_instr;
    rv_pkg::word_t      o_instr_pc;
    logic               i_ls_start;
    logic               i_ls_write;
    logic               i_ls_unsigned;
    logic               o_ls_busy;
    logic               o_ls_done;
    logic               o_ls_misaligned;
    rv_pkg::word_t      i_ls_addr;
    rv_pkg::word_t      i_ls_wdata;
    rv_pkg::word_t      o_ls_rdata;
    rv_pkg::ls_size_e   i_ls_size;
    rv_pkg::word_t      o_wb_adr;
    rv_pkg::word_t      o_wb_dat;
    rv_pkg::word_t      i_wb_dat;
    rv_pkg::bsel_t      o_wb_sel;
    logic               o_wb_we;
    logic               o_wb_stb;
    logic               o_wb_cyc;
    logic               i_wb_ack;

    logic [31:0]        shadow [4096];                  // Expected memory contents.
    logic [15:0]        lfsr = 16'd52582;
    int                 errors = 0;
    int                 checks = 0;
    int                 tests = 0;
    int                 we_cycles = 0;

    rv_top_wb dut (.*);

    tb_wb_mem u_mem
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wb_adr   (o_wb_adr),
        .i_wb_dat   (o_wb_dat),
        .o_wb_dat   (i_wb_dat),
        .i_wb_we    (o_wb_we),
        .i_wb_sel   (o_wb_sel),
        .i_wb_stb   (o_wb_stb),
        .i_wb_cyc   (o_wb_cyc),
        .o_wb_ack   (i_wb_ack)
    );

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk)
        if (o_wb_we)
            we_cycles <= we_cycles + 1;

    function automatic logic [31:0] mem_pattern(input logic [31:0] addr);
        return {4'hc, addr[13:2], 4'h5, ~addr[13:2]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] addr,
                                                input rv_pkg::ls_size_e size, input logic uns);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = shadow[addr[13:2]];
        b = w[8*addr[1:0] +: 8];
        h = w[8*addr[1:0] +: 16];
        if (size == rv_pkg::LS_BYTE)
            return uns ? {24'd0, b} : {{24{b[7]}}, b};
        else if (size == rv_pkg::LS_HALF)
            return uns ? {16'd0, h} : {{16{h[15]}}, h};
        return w;
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t: %s, got %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("sim failed");
        $finish;
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors == err_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - err_before);
    endtask

    // Called on a falling edge; returns on a falling edge.
    task automatic pop_instr(input logic [31:0] pc);
        int n;
        n = 0;
        while (!o_instr_valid && n < TIMEOUT)
        begin
            @(negedge i_clk);
            n++;
        end
        if (!o_instr_valid)
            timed_out("o_instr_valid");
        else
        begin
            compare(o_instr_pc, pc, "instr pc");
            compare(o_instr, mem_pattern(pc), $sformatf("instr at %08h", pc));
            i_instr_pop = 1'b1;
            @(negedge i_clk);
            i_instr_pop = 1'b0;
        end
    endtask

    task automatic redirect(input logic [31:0] pc);
        i_redirect = 1'b1;
        i_redirect_pc = pc;
        @(negedge i_clk);
        i_redirect = 1'b0;
        compare(o_instr_valid, 1'b0, "valid after redirect");
    endtask

    task automatic ls_access(input logic write, input logic [31:0] addr,
                             input logic [31:0] wdata, input rv_pkg::ls_size_e size,
                             input logic uns, output logic [31:0] rdata, output logic mis,
                             output logic busy, output int wait_n);
        @(negedge i_clk);
        i_ls_start = 1'b1;
        i_ls_write = write;
        i_ls_addr = addr;
        i_ls_wdata = wdata;
        i_ls_size = size;
        i_ls_unsigned = uns;
        @(negedge i_clk);
        i_ls_start = 1'b0;
        busy = o_ls_busy;
        wait_n = 0;
        while (!o_ls_done && wait_n < TIMEOUT)
        begin
            @(negedge i_clk);
            wait_n++;
        end
        if (!o_ls_done)
            timed_out("o_ls_done");
        else
        begin
            rdata = o_ls_rdata;
            mis = o_ls_misaligned;
            compare(o_ls_busy, 1'b0, "busy with done");
        end
    endtask

    task automatic store(input logic [31:0] addr, input logic [31:0] wdata,
                         input rv_pkg::ls_size_e size);
        logic [31:0] rdata;
        logic        mis;
        logic        busy;
        int          n;
        ls_access(1'b1, addr, wdata, size, 1'b0, rdata, mis, busy, n);
        compare(mis, 1'b0, "misaligned on store");
        compare(busy, 1'b1, "busy after store start");
        if (size == rv_pkg::LS_BYTE)
            shadow[addr[13:2]][8*addr[1:0] +: 8] = wdata[7:0];
        else if (size == rv_pkg::LS_HALF)
            shadow[addr[13:2]][8*addr[1:0] +: 16] = wdata[15:0];
        else
            shadow[addr[13:2]] = wdata;
    endtask

    task automatic load_check(input logic [31:0] addr, input rv_pkg::ls_size_e size,
                              input logic uns);
        logic [31:0] rdata;
        logic        mis;
        logic        busy;
        int          n;
        ls_access(1'b0, addr, '0, size, uns, rdata, mis, busy, n);
        compare(mis, 1'b0, "misaligned on load");
        compare(busy, 1'b1, "busy after load start");
        compare(rdata, expect_load(addr, size, uns),
                $sformatf("load size %0d unsigned %0d at %08h", size, uns, addr));
    endtask

    task automatic fault_check(input logic write, input logic [31:0] addr,
                               input rv_pkg::ls_size_e size);
        logic [31:0] rdata;
        logic        mis;
        logic        busy;
        int          n;
        ls_access(write, addr, 32'hffff_ffff, size, 1'b0, rdata, mis, busy, n);
        compare(mis, 1'b1, $sformatf("misaligned flag at %08h", addr));
        compare(busy, 1'b0, "busy on fault");
        compare(n, 0, "cycles to done on fault");       // Done one cycle after start.
    endtask

    function automatic logic [31:0] legal_offset(input rv_pkg::ls_size_e size, input int k);
        if (size == rv_pkg::LS_BYTE)
            return k % 4;
        return (size == rv_pkg::LS_HALF) ? 2 * (k % 2) : 0;
    endfunction

    task automatic test_reset_fetch();
        int e;
        e = errors;
        repeat (5) @(negedge i_clk);
        compare({o_wb_cyc, o_wb_stb, o_instr_valid}, 3'b000, "bus and fetch in reset");
        compare({o_ls_busy, o_ls_done, o_ls_misaligned}, 3'b000, "lsu in reset");
        i_rst_n = 1'b1;
        for (int k = 0; k < 8; k++)
            pop_instr(RESET_ADDR + 4 * k);
        end_test("reset fetch", e);
    endtask

    task automatic test_redirect();
        int e;
        int n;
        e = errors;
        redirect(32'h300);
        for (int k = 0; k < 3; k++)
            pop_instr(32'h300 + 4 * k);
        n = 0;
        while (!(o_wb_cyc && !i_wb_ack) && n < TIMEOUT)
        begin
            @(negedge i_clk);
            n++;
        end
        if (!(o_wb_cyc && !i_wb_ack))
            timed_out("a fetch bus cycle before its acknowledge");
        else
        begin
            redirect(32'h340);                          // Fetch in flight.
            for (int k = 0; k < 4; k++)
                pop_instr(32'h340 + 4 * k);
            end_test("redirect", e);
        end
    endtask

    task automatic test_store_load();
        int               e;
        rv_pkg::ls_size_e sz;
        e = errors;
        for (int i = 0; i < 12; i++)
        begin
            sz = rv_pkg::ls_size_e'(i % 3);
            store(32'h1000 + 4 * (i / 4) + legal_offset(sz, i), take_bits(32), sz);
        end
        for (int w = 0; w < 3; w++)
            load_check(32'h1000 + 4 * w, rv_pkg::LS_WORD, 1'b0);
        end_test("stores and word loads", e);
    endtask

    task automatic test_subword();
        int e;
        e = errors;
        store(32'h1100, 32'h80ff_7f01, rv_pkg::LS_WORD);
        for (int a = 0; a < 8; a++)
        begin
            load_check(32'h1100 + a, rv_pkg::LS_BYTE, 1'b0);
            load_check(32'h1100 + a, rv_pkg::LS_BYTE, 1'b1);
            if (a % 2 == 0)
            begin
                load_check(32'h1100 + a, rv_pkg::LS_HALF, 1'b0);
                load_check(32'h1100 + a, rv_pkg::LS_HALF, 1'b1);
            end
        end
        end_test("sub-word loads", e);
    endtask

    task automatic test_contention();
        int e;
        e = errors;
        redirect(32'h400);
        fork
            for (int k = 0; k < 20; k++)
            begin
                pop_instr(32'h400 + 4 * k);
                repeat (take_bits(2)) @(negedge i_clk);
            end
            for (int i = 0; i < 12; i++)
            begin
                store(32'h1200 + 4 * (i % 4) + legal_offset(rv_pkg::ls_size_e'(i % 3), i),
                      32'h9e37_79b9 * (i + 1), rv_pkg::ls_size_e'(i % 3));
                load_check(32'h1200 + 4 * (i % 4), rv_pkg::LS_WORD, 1'b0);
            end
        join
        end_test("contention", e);
    endtask

    task automatic test_misaligned();
        int e;
        int we_before;
        e = errors;
        we_before = we_cycles;
        fault_check(1'b1, 32'h1301, rv_pkg::LS_HALF);
        fault_check(1'b1, 32'h1302, rv_pkg::LS_WORD);
        fault_check(1'b1, 32'h1303, rv_pkg::LS_WORD);
        fault_check(1'b0, 32'h1305, rv_pkg::LS_HALF);
        compare(we_cycles - we_before, 0, "write cycles on faults");
        load_check(32'h1300, rv_pkg::LS_WORD, 1'b0);
        load_check(32'h1304, rv_pkg::LS_WORD, 1'b0);
        end_test("misaligned access", e);
    endtask

    initial
    begin
        i_rst_n = 1'b0;
        i_redirect = 1'b0;
        i_redirect_pc = '0;
        i_instr_pop = 1'b0;
        i_ls_start = 1'b0;
        i_ls_write = 1'b0;
        i_ls_addr = '0;
        i_ls_wdata = '0;
        i_ls_size = rv_pkg::LS_WORD;
        i_ls_unsigned = 1'b0;
        for (int i = 0; i < 4096; i++)
            shadow[i] = mem_pattern(4 * i);
        test_reset_fetch();
        test_redirect();
        test_store_load();
        test_subword();
        test_contention();
        test_misaligned();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
rv_pkg.sv
rv_bus_if.sv
rv_fetch.sv
rv_lsu.sv
rv_wb_arbiter.sv
rv_top_wb.sv
tb_wb_mem.sv
tb_rv_top_wb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_rv_top_wb
./obj_dir/Vtb_rv_top_wb | tee sim.log

if grep -qx "sim passed" sim.log
then
    exit 0
else
    exit 1
fi
